/* flist.f */
lsu_pkg.sv
lsu_issue.sv
lsu_read_ctrl.sv
lsu_write_ctrl.sv
lsu_load_align.sv
lsu_top.sv
tb_clock.sv
tb_checker.sv
tb_top.sv

/* lsu_issue.sv */
`timescale 1ns/1ns

module lsu_issue #(
	parameter int ADDR_W = 32
) (
	input  logic clock,
	input  logic reset,
	input  logic req_valid,
	input  lsu_pkg::lsu_req_t req,
	output logic allowin,
	input  logic rd_finish,
	input  logic wr_finish,
	output logic busy,
	output lsu_pkg::lsu_req_t cur_req,
	output lsu_pkg::access_plan_t plan
);
	import lsu_pkg::*;

	logic accept;
	logic [3:0] size_mask;
	logic [2*STRB_W-1:0] strb_span;
	logic [BUS_W-1:0] store_word;
	logic [2*BUS_W-1:0] store_dup;
	logic [ADDR_W-1:0] aligned;

	// busy drops on the finish edge, so done always sees an empty stage
	assign allowin = !busy;
	assign accept = req_valid && allowin;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
		end else if (accept) begin
			busy <= 1'b1;
		end else if (rd_finish || wr_finish) begin
			busy <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			cur_req <= req;
		end
	end

	// bytes touched, before shifting to the lane
	always_comb begin
		case (cur_req.op)
			OP_LW, OP_SW: size_mask = 4'b1111;
			OP_LH, OP_LHU, OP_SH: size_mask = 4'b0011;
			default: size_mask = 4'b0001;
		endcase
	end

	// upper half of the span spills into the next 8-byte word
	assign strb_span = {{(2*STRB_W-4){1'b0}}, size_mask} << cur_req.addr[2:0];
	assign aligned = {cur_req.addr[ADDR_W-1:3], 3'b000};

	// rotate left by lane bytes, same word for both beats
	assign store_word = {{(BUS_W-DATA_W){1'b0}}, cur_req.data};
	assign store_dup = {store_word, store_word} << {cur_req.addr[2:0], 3'b000};

	always_comb begin
		plan = '0;
		plan.base[ADDR_W-1:0] = aligned;
		plan.lane = cur_req.addr[2:0];
		plan.strb_first = strb_span[STRB_W-1:0];
		plan.strb_second = strb_span[2*STRB_W-1:STRB_W];
		plan.two_beats = |strb_span[2*STRB_W-1:STRB_W];
		plan.wdata = store_dup[2*BUS_W-1:BUS_W];
	end

	// channel machines only finish work that this stage handed out
	a_finish_needs_busy: assert property (@(posedge clock) disable iff (reset)
		(rd_finish || wr_finish) |-> busy);

endmodule

/* lsu_load_align.sv */
`timescale 1ns/1ns

module lsu_load_align (
	input  logic clock,
	input  logic reset,
	input  lsu_pkg::lsu_req_t cur_req,
	input  lsu_pkg::access_plan_t plan,
	input  logic [lsu_pkg::BUS_W-1:0] first_rdata,
	input  logic [lsu_pkg::BUS_W-1:0] last_rdata,
	input  logic rd_finish,
	input  logic wr_finish,
	output logic wb_valid,
	output logic [lsu_pkg::REG_W-1:0] wb_rd,
	output logic [lsu_pkg::DATA_W-1:0] wb_data,
	output logic done
);
	import lsu_pkg::*;

	logic [2*BUS_W-1:0] window;
	logic [2*BUS_W-1:0] shifted;
	logic [DATA_W-1:0] picked;
	logic [DATA_W-1:0] load_val;

	// split access: first beat holds the low bytes, last beat the high ones
	assign window = plan.two_beats ? {last_rdata, first_rdata}
		: {{BUS_W{1'b0}}, last_rdata};
	assign shifted = window >> {plan.lane, 3'b000};
	assign picked = shifted[DATA_W-1:0];

	always_comb begin
		case (cur_req.op)
			OP_LB: load_val = {{(DATA_W-8){picked[7]}}, picked[7:0]};
			OP_LBU: load_val = {{(DATA_W-8){1'b0}}, picked[7:0]};
			OP_LH: load_val = {{(DATA_W-16){picked[15]}}, picked[15:0]};
			OP_LHU: load_val = {{(DATA_W-16){1'b0}}, picked[15:0]};
			default: load_val = picked;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wb_valid <= 1'b0;
			done <= 1'b0;
		end else begin
			wb_valid <= rd_finish;
			done <= rd_finish || wr_finish;
		end
	end

	always_ff @(posedge clock) begin
		if (rd_finish) begin
			wb_rd <= cur_req.rd;
			wb_data <= load_val;
		end
	end

endmodule

/* lsu_pkg.sv */
package lsu_pkg;

	parameter int DATA_W = 32;
	parameter int BUS_W = 64;
	parameter int STRB_W = 8;
	parameter int REG_W = 5;

	typedef enum logic [3:0] {
		OP_LW,
		OP_LH,
		OP_LHU,
		OP_LB,
		OP_LBU,
		OP_SW,
		OP_SH,
		OP_SB
	} lsu_op_e;

	// effective address already computed upstream
	typedef struct packed {
		lsu_op_e op;
		logic [31:0] addr;
		logic [DATA_W-1:0] data;
		logic [REG_W-1:0] rd;
	} lsu_req_t;

	// how one request maps onto the 8-byte bus
	typedef struct packed {
		logic [31:0] base;
		logic [2:0] lane;
		logic two_beats;
		logic [STRB_W-1:0] strb_first;
		logic [STRB_W-1:0] strb_second;
		logic [BUS_W-1:0] wdata;
	} access_plan_t;

	typedef struct packed {
		logic [BUS_W-1:0] data;
		logic [STRB_W-1:0] strb;
		logic last;
	} beat_t;

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ADDR,
		RD_DATA,
		RD_NEXT
	} rd_state_e;

	typedef enum logic [2:0] {
		WR_IDLE,
		WR_ADDR,
		WR_DATA,
		WR_RESP,
		WR_NEXT
	} wr_state_e;

endpackage

/* lsu_read_ctrl.sv */
`timescale 1ns/1ns

module lsu_read_ctrl #(
	parameter int ADDR_W = 32,
	parameter int ID_W = 4
) (
	input  logic clock,
	input  logic reset,
	input  logic busy,
	input  lsu_pkg::lsu_req_t cur_req,
	input  lsu_pkg::access_plan_t plan,
	output logic arvalid,
	output logic [ADDR_W-1:0] araddr,
	output logic [ID_W-1:0] arid,
	input  logic arready,
	input  logic rvalid,
	input  logic [lsu_pkg::BUS_W-1:0] rdata,
	input  logic [ID_W-1:0] rid,
	output logic rready,
	output logic rd_finish,
	output logic [lsu_pkg::BUS_W-1:0] first_rdata,
	output logic [lsu_pkg::BUS_W-1:0] last_rdata
);
	import lsu_pkg::*;

	rd_state_e state;
	rd_state_e state_next;
	logic [ID_W-1:0] id_cnt;
	logic second;
	logic is_load;
	logic beat_ok;

	assign is_load = cur_req.op inside {OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU};

	// free-running id source
	always_ff @(posedge clock) begin
		if (reset) begin
			id_cnt <= '0;
		end else begin
			id_cnt <= id_cnt + 1'b1;
		end
	end

	assign arvalid = (state == RD_ADDR);
	assign rready = (state == RD_DATA);
	// beats with a stale id are taken off the bus and dropped
	assign beat_ok = rvalid && rready && (rid == arid);
	assign rd_finish = beat_ok && (!plan.two_beats || second);
	assign last_rdata = rdata;

	always_comb begin
		state_next = state;
		case (state)
			RD_IDLE: if (busy && is_load) state_next = RD_ADDR;
			RD_ADDR: if (arready) state_next = RD_DATA;
			RD_DATA: begin
				if (beat_ok) begin
					state_next = rd_finish ? RD_IDLE : RD_NEXT;
				end
			end
			RD_NEXT: state_next = RD_ADDR;
			default: state_next = RD_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= RD_IDLE;
			second <= 1'b0;
		end else begin
			state <= state_next;
			if (state == RD_IDLE) begin
				second <= 1'b0;
			end else if (state == RD_NEXT) begin
				second <= 1'b1;
			end
		end
	end

	// address and id are captured on the cycle before arvalid rises
	always_ff @(posedge clock) begin
		if (state == RD_IDLE || state == RD_NEXT) begin
			araddr <= (state == RD_NEXT) ? plan.base[ADDR_W-1:0] + ADDR_W'(8)
				: plan.base[ADDR_W-1:0];
			arid <= id_cnt;
		end
		if (beat_ok && !second) begin
			first_rdata <= rdata;
		end
	end

	a_ar_hold: assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid));

endmodule

/* lsu_top.sv */
`timescale 1ns/1ns

module lsu_top #(
	parameter int ADDR_W = 32,
	parameter int ID_W = 4
) (
	input  logic clock,
	input  logic reset,
	input  logic req_valid,
	input  lsu_pkg::lsu_req_t req,
	output logic allowin,
	output logic arvalid,
	output logic [ADDR_W-1:0] araddr,
	output logic [ID_W-1:0] arid,
	input  logic arready,
	input  logic rvalid,
	input  logic [lsu_pkg::BUS_W-1:0] rdata,
	input  logic [ID_W-1:0] rid,
	output logic rready,
	output logic awvalid,
	output logic [ADDR_W-1:0] awaddr,
	output logic [ID_W-1:0] awid,
	input  logic awready,
	output logic wvalid,
	output lsu_pkg::beat_t wbeat,
	input  logic wready,
	input  logic bvalid,
	input  logic [ID_W-1:0] bid,
	output logic bready,
	output logic wb_valid,
	output logic [lsu_pkg::REG_W-1:0] wb_rd,
	output logic [lsu_pkg::DATA_W-1:0] wb_data,
	output logic done
);
	import lsu_pkg::*;

	logic busy;
	logic rd_finish;
	logic wr_finish;
	lsu_req_t cur_req;
	access_plan_t plan;
	logic [BUS_W-1:0] first_rdata;
	logic [BUS_W-1:0] last_rdata;

	lsu_issue #(.ADDR_W(ADDR_W)) u_issue (
		.clock(clock), .reset(reset), .req_valid(req_valid), .req(req),
		.allowin(allowin), .rd_finish(rd_finish), .wr_finish(wr_finish),
		.busy(busy), .cur_req(cur_req), .plan(plan)
	);

	lsu_read_ctrl #(.ADDR_W(ADDR_W), .ID_W(ID_W)) u_read (
		.clock(clock), .reset(reset), .busy(busy), .cur_req(cur_req), .plan(plan),
		.arvalid(arvalid), .araddr(araddr), .arid(arid), .arready(arready),
		.rvalid(rvalid), .rdata(rdata), .rid(rid), .rready(rready),
		.rd_finish(rd_finish), .first_rdata(first_rdata), .last_rdata(last_rdata)
	);

	lsu_write_ctrl #(.ADDR_W(ADDR_W), .ID_W(ID_W)) u_write (
		.clock(clock), .reset(reset), .busy(busy), .cur_req(cur_req), .plan(plan),
		.awvalid(awvalid), .awaddr(awaddr), .awid(awid), .awready(awready),
		.wvalid(wvalid), .wbeat(wbeat), .wready(wready),
		.bvalid(bvalid), .bid(bid), .bready(bready), .wr_finish(wr_finish)
	);

	lsu_load_align u_align (
		.clock(clock), .reset(reset), .cur_req(cur_req), .plan(plan),
		.first_rdata(first_rdata), .last_rdata(last_rdata),
		.rd_finish(rd_finish), .wr_finish(wr_finish),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data), .done(done)
	);

endmodule

/* lsu_write_ctrl.sv */
`timescale 1ns/1ns

module lsu_write_ctrl #(
	parameter int ADDR_W = 32,
	parameter int ID_W = 4
) (
	input  logic clock,
	input  logic reset,
	input  logic busy,
	input  lsu_pkg::lsu_req_t cur_req,
	input  lsu_pkg::access_plan_t plan,
	output logic awvalid,
	output logic [ADDR_W-1:0] awaddr,
	output logic [ID_W-1:0] awid,
	input  logic awready,
	output logic wvalid,
	output lsu_pkg::beat_t wbeat,
	input  logic wready,
	input  logic bvalid,
	input  logic [ID_W-1:0] bid,
	output logic bready,
	output logic wr_finish
);
	import lsu_pkg::*;

	wr_state_e state;
	wr_state_e state_next;
	logic [ID_W-1:0] id_cnt;
	logic second;
	logic is_store;
	logic resp_ok;

	assign is_store = cur_req.op inside {OP_SW, OP_SH, OP_SB};

	always_ff @(posedge clock) begin
		if (reset) begin
			id_cnt <= '0;
		end else begin
			id_cnt <= id_cnt + 1'b1;
		end
	end

	assign awvalid = (state == WR_ADDR);
	assign wvalid = (state == WR_DATA);
	assign bready = (state == WR_RESP);
	assign resp_ok = bvalid && bready && (bid == awid);
	assign wr_finish = resp_ok && (!plan.two_beats || second);

	// each beat is its own single-beat burst
	always_comb begin
		wbeat.data = plan.wdata;
		wbeat.strb = second ? plan.strb_second : plan.strb_first;
		wbeat.last = 1'b1;
	end

	always_comb begin
		state_next = state;
		case (state)
			WR_IDLE: if (busy && is_store) state_next = WR_ADDR;
			WR_ADDR: if (awready) state_next = WR_DATA;
			WR_DATA: if (wready) state_next = WR_RESP;
			WR_RESP: begin
				if (resp_ok) begin
					state_next = wr_finish ? WR_IDLE : WR_NEXT;
				end
			end
			WR_NEXT: state_next = WR_ADDR;
			default: state_next = WR_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= WR_IDLE;
			second <= 1'b0;
		end else begin
			state <= state_next;
			if (state == WR_IDLE) begin
				second <= 1'b0;
			end else if (state == WR_NEXT) begin
				second <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (state == WR_IDLE || state == WR_NEXT) begin
			awaddr <= (state == WR_NEXT) ? plan.base[ADDR_W-1:0] + ADDR_W'(8)
				: plan.base[ADDR_W-1:0];
			awid <= id_cnt;
		end
	end

	// data phase follows the accepted address of the same beat
	a_w_after_aw: assert property (@(posedge clock) disable iff (reset)
		$rose(wvalid) |-> $past(awvalid && awready));

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_top -f flist.f -o sim_lsu
./obj_dir/sim_lsu > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"

/* tb_checker.sv */
`timescale 1ns/1ns

module tb_checker #(
	parameter int ID_W = 4
) (
	input  logic clock,
	input  logic reset,
	input  logic req_valid,
	input  lsu_pkg::lsu_req_t req,
	input  logic allowin,
	input  logic arvalid,
	input  logic [31:0] araddr,
	input  logic [ID_W-1:0] arid,
	input  logic arready,
	input  logic awvalid,
	input  logic [31:0] awaddr,
	input  logic [ID_W-1:0] awid,
	input  logic awready,
	input  logic wvalid,
	input  lsu_pkg::beat_t wbeat,
	input  logic wready,
	input  logic wb_valid,
	input  logic [lsu_pkg::REG_W-1:0] wb_rd,
	input  logic [lsu_pkg::DATA_W-1:0] wb_data,
	input  logic done,
	output int error_count,
	output int done_count
);
	import lsu_pkg::*;

	typedef struct packed {
		logic is_load;
		logic [REG_W-1:0] rd;
		logic [DATA_W-1:0] data;
	} result_t;

	// byte copy of the 256-byte window by low address byte
	logic [7:0] model [0:255];
	result_t results [$];
	logic [31:0] ar_expect [$];
	logic [31:0] aw_expect [$];
	logic ar_held;
	logic aw_held;
	logic [31:0] ar_held_addr;
	logic [31:0] aw_held_addr;
	logic [ID_W-1:0] ar_held_id;
	logic [ID_W-1:0] aw_held_id;

	function automatic logic [7:0] fill_byte(input int a);
		return 8'(a * 37 + 29);
	endfunction

	function automatic int access_size(input lsu_op_e op);
		case (op)
			OP_LW, OP_SW: return 4;
			OP_LH, OP_LHU, OP_SH: return 2;
			default: return 1;
		endcase
	endfunction

	function automatic logic is_load_op(input lsu_op_e op);
		return op inside {OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU};
	endfunction

	function automatic logic [31:0] expected_load(input lsu_req_t r);
		logic [31:0] raw;
		raw = '0;
		for (int i = 0; i < 4; i++) begin
			raw = raw | (32'(model[r.addr[7:0] + 8'(i)]) << (8 * i));
		end
		case (r.op)
			OP_LH: return {{16{raw[15]}}, raw[15:0]};
			OP_LHU: return {16'h0000, raw[15:0]};
			OP_LB: return {{24{raw[7]}}, raw[7:0]};
			OP_LBU: return {24'h000000, raw[7:0]};
			default: return raw;
		endcase
	endfunction

	task automatic apply_store(input lsu_req_t r);
		for (int i = 0; i < access_size(r.op); i++) begin
			model[r.addr[7:0] + 8'(i)] = 8'(r.data >> (8 * i));
		end
	endtask

	task automatic flag_value(input string name, input logic [31:0] got, input logic [31:0] want);
		$display("FAILED %s: got %h expected %h at %0t", name, got, want, $time);
		error_count++;
	endtask

	task automatic flag_event(input string what);
		$display("error at %0t: %s", $time, what);
		error_count++;
	endtask

	task automatic record_request(input lsu_req_t r);
		logic [31:0] base;
		logic split;
		result_t res;
		base = {r.addr[31:3], 3'b000};
		split = (int'(r.addr[2:0]) + access_size(r.op)) > 8;
		res.is_load = is_load_op(r.op);
		res.rd = r.rd;
		res.data = '0;
		if (res.is_load) begin
			res.data = expected_load(r);
			ar_expect.push_back(base);
			if (split) begin
				ar_expect.push_back(base + 32'd8);
			end
		end else begin
			apply_store(r);
			aw_expect.push_back(base);
			if (split) begin
				aw_expect.push_back(base + 32'd8);
			end
		end
		results.push_back(res);
	endtask

	initial begin
		error_count = 0;
		done_count = 0;
		for (int i = 0; i < 256; i++) begin
			model[8'(i)] = fill_byte(i);
		end
	end

	always @(posedge clock) begin
		result_t exp;
		logic [31:0] want;
		if (reset) begin
			ar_held = 1'b0;
			aw_held = 1'b0;
		end else begin
			// retire first since a new request can be taken on this same edge
			if (done) begin
				done_count++;
				if (results.size() == 0) begin
					flag_event("done pulsed with no request outstanding");
				end else begin
					exp = results.pop_front();
					if (exp.is_load && !wb_valid) begin
						flag_event("load finished without wb_valid");
					end
					if (!exp.is_load && wb_valid) begin
						flag_event("store pulsed wb_valid");
					end
					if (exp.is_load && wb_rd != exp.rd) begin
						flag_value("wb_rd", 32'(wb_rd), 32'(exp.rd));
					end
					if (exp.is_load && wb_data != exp.data) begin
						flag_value("wb_data", wb_data, exp.data);
					end
				end
			end else if (wb_valid) begin
				flag_event("wb_valid pulsed without done");
			end

			// address and id must hold under back-pressure
			if (ar_held && !arvalid) begin
				flag_event("arvalid dropped before arready");
			end else if (ar_held) begin
				if (araddr != ar_held_addr) begin
					flag_value("araddr", araddr, ar_held_addr);
				end
				if (arid != ar_held_id) begin
					flag_value("arid", 32'(arid), 32'(ar_held_id));
				end
			end
			if (aw_held && !awvalid) begin
				flag_event("awvalid dropped before awready");
			end else if (aw_held) begin
				if (awaddr != aw_held_addr) begin
					flag_value("awaddr", awaddr, aw_held_addr);
				end
				if (awid != aw_held_id) begin
					flag_value("awid", 32'(awid), 32'(aw_held_id));
				end
			end

			if (arvalid && arready) begin
				if (ar_expect.size() == 0) begin
					flag_event("read address issued with no load pending");
				end else begin
					want = ar_expect.pop_front();
					if (araddr != want) begin
						flag_value("araddr", araddr, want);
					end
				end
			end
			if (awvalid && awready) begin
				if (aw_expect.size() == 0) begin
					flag_event("write address issued with no store pending");
				end else begin
					want = aw_expect.pop_front();
					if (awaddr != want) begin
						flag_value("awaddr", awaddr, want);
					end
				end
			end

			// every write beat is a burst of its own
			if (wvalid && wready && !wbeat.last) begin
				flag_value("wbeat.last", 32'(wbeat.last), 32'h1);
			end

			ar_held = arvalid && !arready;
			ar_held_addr = araddr;
			ar_held_id = arid;
			aw_held = awvalid && !awready;
			aw_held_addr = awaddr;
			aw_held_id = awid;

			if (req_valid && allowin) begin
				record_request(req);
			end
		end
	end

endmodule

/* tb_clock.sv */
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD = 20,
	parameter int RESET_CYCLES = 4
) (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever begin
			#(PERIOD / 2) clock = ~clock;
		end
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
	end

endmodule

/* tb_top.sv */
`timescale 1ns/1ns

module tb_top;
	import lsu_pkg::*;

	localparam int ID_W = 4;
	localparam int NUM_REQ = 300;
	localparam int CLOCK_NS = 20;
	localparam logic [31:0] WIN_BASE = 32'h0000_2000;
	localparam logic [31:0] SEED = 32'h5aedf3b5;
	localparam longint TIMEOUT_NS = longint'(NUM_REQ) * 400 * CLOCK_NS + 1000;

	logic clock;
	logic reset;
	logic req_valid;
	lsu_req_t req;
	logic allowin;
	logic arvalid;
	logic [31:0] araddr;
	logic [ID_W-1:0] arid;
	logic arready;
	logic rvalid;
	logic [BUS_W-1:0] rdata;
	logic [ID_W-1:0] rid;
	logic rready;
	logic awvalid;
	logic [31:0] awaddr;
	logic [ID_W-1:0] awid;
	logic awready;
	logic wvalid;
	beat_t wbeat;
	logic wready;
	logic bvalid;
	logic [ID_W-1:0] bid;
	logic bready;
	logic wb_valid;
	logic [REG_W-1:0] wb_rd;
	logic [DATA_W-1:0] wb_data;
	logic done;
	int error_count;
	int done_count;

	// responder memory of 32 words wrapping over the window
	logic [BUS_W-1:0] mem [0:31];

	tb_clock #(.PERIOD(CLOCK_NS), .RESET_CYCLES(4)) u_clock (.*);
	lsu_top #(.ADDR_W(32), .ID_W(ID_W)) DUT (.*);
	tb_checker #(.ID_W(ID_W)) u_checker (.*);

	function automatic logic [7:0] fill_byte(input int a);
		return 8'(a * 37 + 29);
	endfunction

	function automatic lsu_req_t random_request();
		lsu_req_t r;
		r.op = lsu_op_e'(3'($urandom));
		r.addr = WIN_BASE + ($urandom & 32'h0000_00ff);
		r.data = $urandom;
		r.rd = 5'($urandom);
		return r;
	endfunction

	task automatic random_wait(input int max_cycles);
		repeat ($urandom % (max_cycles + 1)) @(negedge clock);
	endtask

	task automatic send_request(input lsu_req_t r);
		random_wait(3);
		req = r;
		req_valid = 1'b1;
		while (!allowin) begin
			@(negedge clock);
		end
		@(negedge clock);
		req_valid = 1'b0;
	endtask

	task automatic send_read_beat(input logic [BUS_W-1:0] data, input logic [ID_W-1:0] id);
		rdata = data;
		rid = id;
		rvalid = 1'b1;
		while (!rready) begin
			@(negedge clock);
		end
		@(negedge clock);
		rvalid = 1'b0;
	endtask

	task automatic write_word(input logic [31:0] addr, input beat_t beat);
		logic [2:0] lane;
		for (int b = 0; b < 8; b++) begin
			lane = 3'(b);
			if (beat.strb[lane]) begin
				mem[addr[7:3]][{lane, 3'b000} +: 8] = 8'(beat.data >> (8 * b));
			end
		end
	endtask

	initial begin : memory_fill
		logic [7:0] a;
		for (int i = 0; i < 256; i++) begin
			a = 8'(i);
			mem[a[7:3]][{a[2:0], 3'b000} +: 8] = fill_byte(i);
		end
	end

	initial begin : read_responder
		logic [31:0] addr;
		logic [ID_W-1:0] id;
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		rid = '0;
		forever begin
			@(negedge clock);
			if (arvalid) begin
				random_wait(3);
				arready = 1'b1;
				addr = araddr;
				id = arid;
				@(negedge clock);
				arready = 1'b0;
				random_wait(3);
				// stale beat with a foreign id now and then
				if ($urandom % 4 == 0) begin
					send_read_beat({$urandom, $urandom}, id + 1'b1);
				end
				send_read_beat(mem[addr[7:3]], id);
			end
		end
	end

	initial begin : write_responder
		logic [31:0] addr;
		logic [ID_W-1:0] id;
		beat_t beat;
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		bid = '0;
		forever begin
			@(negedge clock);
			if (awvalid) begin
				random_wait(3);
				awready = 1'b1;
				addr = awaddr;
				id = awid;
				@(negedge clock);
				awready = 1'b0;
				while (!wvalid) begin
					@(negedge clock);
				end
				random_wait(2);
				wready = 1'b1;
				beat = wbeat;
				@(negedge clock);
				wready = 1'b0;
				write_word(addr, beat);
				random_wait(3);
				bvalid = 1'b1;
				bid = id;
				while (!bready) begin
					@(negedge clock);
				end
				@(negedge clock);
				bvalid = 1'b0;
			end
		end
	end

	initial begin : stimulus
		void'($urandom(SEED));
		req_valid = 1'b0;
		req = '0;
		@(negedge reset);
		@(negedge clock);
		for (int n = 0; n < NUM_REQ; n++) begin
			send_request(random_request());
		end
		while (done_count < NUM_REQ) begin
			@(negedge clock);
		end
		// a few idle cycles to catch stray pulses
		repeat (10) @(negedge clock);
		$display("errors: %0d, requests done: %0d of %0d", error_count, done_count, NUM_REQ);
		if (error_count == 0 && done_count == NUM_REQ) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("timeout: %0d errors, only %0d of %0d requests done",
			error_count, done_count, NUM_REQ);
		$display("TEST FAILED");
		$finish;
	end

endmodule
